// File: common/fb_consts.svh
/* raster timing, framebuffer geometry, border colour
   and output pipeline latency */
`ifndef FB_CONSTS_SVH
`define FB_CONSTS_SVH

// horizontal timing in pixels
`define H_ACTIVE 20
`define H_TOTAL 28
`define HS_START 22 // hsync starts after front porch
`define HS_END 24

// vertical timing in lines
`define V_ACTIVE 14
`define V_TOTAL 18
`define VS_START 15
`define VS_END 16

// framebuffer at top-left of active area
`define FB_WIDTH 16
`define FB_HEIGHT 12
`define FB_PIXELS 192 // width * height

// interleaved banks, pixel address mod 4 picks bank
`define FB_BANKS 4
`define BANK_DEPTH 48

`define BORDER_COLR 12'h137 // shown outside framebuffer

// coords to rgb: read reg +1, bank +1, clut +1
`define FETCH_LAT 3

`endif

// File: common/colour_pkg.sv
/* colour types: palette index, rgb triple
   and the host data word with its two views */
package colour_pkg;

    typedef logic [3:0] cidx_t; // palette index, one per pixel

    // 12-bit colour, 4 bits a channel
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // pixel write view of a host word
    typedef struct packed {
        logic [7:0] pad; // ignored on pixel writes
        cidx_t      idx; // colour index in low nibble
    } host_pix_t;

    // one host word, decoded by wr_pal
    typedef union packed {
        rgb_t      colr; // palette write
        host_pix_t pix;  // pixel write
    } host_word_u;

endpackage

// File: common/display_pkg.sv
/* coordinate and framebuffer address types */
package display_pkg;

    // signed so windows may start left of or above the active area
    typedef logic signed [15:0] coord_t;

    typedef logic [7:0] fb_addr_t;   // linear pixel address, 0..191
    typedef logic [5:0] bank_addr_t; // address within one bank, 0..47

endpackage

// File: design/display_timing.sv
/* display timing generator: pixel and line counters,
   active-high syncs, data enable and frame strobe */
`timescale 1ns/1ps
`include "fb_consts.svh"

module display_timing import display_pkg::*; (
    input  logic   clk_pix,
    input  logic   rst_n,
    output coord_t sx,    // horizontal position, 0 at first active pixel
    output coord_t sy,    // vertical position, 0 at first active line
    output logic   hsync,
    output logic   vsync,
    output logic   de,    // active picture
    output logic   frame  // one cycle at start of frame
);

    logic line_end; // last pixel of a line
    logic frame_end;

    assign line_end  = (sx == `H_TOTAL - 1);
    assign frame_end = (sy == `V_TOTAL - 1);

    // sx every clock, sy on sx wrap
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (line_end) begin
            sx <= '0;
            if (frame_end) begin
                sy <= '0; // back to top
            end else begin
                sy <= sy + 16'sd1;
            end
        end else begin
            sx <= sx + 16'sd1;
        end
    end

    // decode from counters
    always_comb begin
        hsync = (sx >= `HS_START) && (sx < `HS_END);
        vsync = (sy >= `VS_START) && (sy < `VS_END);
        de    = (sx < `H_ACTIVE) && (sy < `V_ACTIVE);
        frame = (sx == 0) && (sy == 0);
    end

    // hsync sits in horizontal blanking only
    a_hsync_blank: assert property (
        @(posedge clk_pix) disable iff (!rst_n) !(hsync && de)
    ) else $error("hsync during active picture");

endmodule

// File: framebuffer/fb_host_port.sv
/* host write port: four-phase req/ack slave,
   decodes host words into bank and palette writes */
`timescale 1ns/1ps
`include "fb_consts.svh"

module fb_host_port import colour_pkg::*; import display_pkg::*; (
    input  logic                 clk_pix,
    input  logic                 rst_n,
    input  logic                 req,
    output logic                 ack,
    input  logic                 wr_pal,     // 1: palette, 0: pixel
    input  fb_addr_t             wr_addr,
    input  host_word_u           wr_data,
    output logic [`FB_BANKS-1:0] bank_we,    // one strobe per bank
    output bank_addr_t           bank_waddr, // shared by all banks
    output cidx_t                bank_wdata,
    output logic                 pal_we,
    output cidx_t                pal_waddr,
    output rgb_t                 pal_wdata
);

    localparam int SEL_W = $clog2(`FB_BANKS); // bank select bits

    typedef enum logic [1:0] {
        ST_IDLE,     // waiting for req
        ST_WRITE,    // one cycle, write strobe out
        ST_WAIT_LOW  // ack high until req drops
    } state_t;

    state_t           state;
    logic [SEL_W-1:0] wr_bank; // low address bits pick the bank
    logic             pix_ok;  // pixel address inside framebuffer

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:     if (req) state <= ST_WRITE;
                ST_WRITE:    state <= ST_WAIT_LOW; // write lands on this edge
                ST_WAIT_LOW: if (!req) state <= ST_IDLE;
                default:     state <= ST_IDLE;
            endcase
        end
    end

    assign ack = (state == ST_WAIT_LOW); // rises together with the write

    assign wr_bank = wr_addr[SEL_W-1:0];
    assign pix_ok  = (wr_addr < `FB_PIXELS);

    // data paths always driven, strobes decide
    always_comb begin
        bank_waddr = bank_addr_t'(wr_addr >> SEL_W); // addr div 4
        bank_wdata = wr_data.pix.idx;                // index view
        pal_waddr  = wr_addr[3:0];
        pal_wdata  = wr_data.colr;                   // rgb view
        bank_we    = '0;
        pal_we     = 1'b0;
        if (state == ST_WRITE) begin
            if (wr_pal) begin
                pal_we = 1'b1;
            end else if (pix_ok) begin
                bank_we[wr_bank] = 1'b1;
            end // out-of-range pixel writes dropped, still acked
        end
    end

    // req seen on the edge that raised ack
    a_ack_after_req: assert property (
        @(posedge clk_pix) disable iff (!rst_n) $rose(ack) |-> $past(req)
    ) else $error("ack rose without req");

    a_one_strobe: assert property (
        @(posedge clk_pix) disable iff (!rst_n) $onehot0({bank_we, pal_we})
    ) else $error("more than one write strobe");

endmodule

// File: framebuffer/fb_bank.sv
/* one framebuffer bank: simple dual-port memory,
   synchronous write, registered read */
`timescale 1ns/1ps
`include "fb_consts.svh"

module fb_bank import colour_pkg::*; import display_pkg::*; (
    input  logic       clk_pix,
    input  logic       we,
    input  bank_addr_t waddr,
    input  cidx_t      wdata,
    input  bank_addr_t raddr,
    output cidx_t      rdata  // valid one cycle after raddr
);

    cidx_t mem [`BANK_DEPTH]; // every fourth pixel

    // host side
    always_ff @(posedge clk_pix) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // video side, write-then-read ordering not relied on
    always_ff @(posedge clk_pix) begin
        rdata <= mem[raddr];
    end

endmodule

// File: framebuffer/fb_fetch.sv
/* framebuffer fetch: window test, bank address,
   bank select mux and sync delay pipeline */
`timescale 1ns/1ps
`include "fb_consts.svh"

module fb_fetch import colour_pkg::*; import display_pkg::*; (
    input  logic       clk_pix,
    input  logic       rst_n,
    input  coord_t     sx,
    input  coord_t     sy,
    input  logic       hsync,
    input  logic       vsync,
    input  logic       de,
    output bank_addr_t bank_raddr,              // same address to every bank
    input  cidx_t      bank_rdata [`FB_BANKS],
    output cidx_t      cidx,                    // selected bank result
    output logic       paint_area,              // cidx belongs to framebuffer
    output logic       hsync_d,                 // syncs, FETCH_LAT late
    output logic       vsync_d,
    output logic       de_d
);

    localparam int SEL_W = $clog2(`FB_BANKS);

    logic                  in_win;   // coords inside framebuffer
    fb_addr_t              pix_addr; // linear address, y*16 + x
    logic [SEL_W-1:0]      sel_q1;   // bank select, with raddr
    logic [SEL_W-1:0]      sel_q2;   // bank select, with rdata
    logic                  paint_q1;
    logic                  paint_q2;
    logic [`FETCH_LAT-1:0] hs_pipe;  // shift regs, msb is oldest
    logic [`FETCH_LAT-1:0] vs_pipe;
    logic [`FETCH_LAT-1:0] de_pipe;

    always_comb begin
        in_win   = (sx >= 0) && (sx < `FB_WIDTH) && (sy >= 0) && (sy < `FB_HEIGHT);
        pix_addr = fb_addr_t'(sy * `FB_WIDTH + sx); // truncation harmless in window
    end

    // stage 1 address; parked at 0 outside window so banks stay in range
    always_ff @(posedge clk_pix) begin
        bank_raddr <= in_win ? bank_addr_t'(pix_addr >> SEL_W) : '0;
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sel_q1   <= '0;
            sel_q2   <= '0;
            paint_q1 <= 1'b0;
            paint_q2 <= 1'b0;
            hs_pipe  <= '0;
            vs_pipe  <= '0;
            de_pipe  <= '0;
        end else begin
            sel_q1   <= pix_addr[SEL_W-1:0]; // addr mod 4
            paint_q1 <= in_win;
            sel_q2   <= sel_q1;   // lines up with bank output
            paint_q2 <= paint_q1;
            hs_pipe  <= {hs_pipe[`FETCH_LAT-2:0], hsync};
            vs_pipe  <= {vs_pipe[`FETCH_LAT-2:0], vsync};
            de_pipe  <= {de_pipe[`FETCH_LAT-2:0], de};
        end
    end

    assign cidx       = bank_rdata[sel_q2]; // stage 2
    assign paint_area = paint_q2;

    // full latency, aligned with clut output
    assign hsync_d = hs_pipe[`FETCH_LAT-1];
    assign vsync_d = vs_pipe[`FETCH_LAT-1];
    assign de_d    = de_pipe[`FETCH_LAT-1];

    a_addr_range: assert property (
        @(posedge clk_pix) disable iff (!rst_n) in_win |-> (pix_addr < `FB_PIXELS)
    ) else $error("pixel address beyond framebuffer");

endmodule

// File: design/clut.sv
/* colour lookup table: 16-entry palette with host write,
   registered colour out, border and blanking paint */
`timescale 1ns/1ps
`include "fb_consts.svh"

module clut import colour_pkg::*; (
    input  logic  clk_pix,
    input  logic  rst_n,
    input  logic  pal_we,
    input  cidx_t pal_waddr,
    input  rgb_t  pal_wdata,
    input  cidx_t cidx,       // from bank mux, stage 2
    input  logic  paint_area, // stage 2
    input  logic  de,         // already at output timing
    output rgb_t  rgb
);

    localparam int PAL_DEPTH = 2 ** $bits(cidx_t);

    rgb_t pal [PAL_DEPTH]; // palette entries
    rgb_t colr_q;          // stage 3 colour

    // host writes land at once, even mid-frame
    always_ff @(posedge clk_pix) begin
        if (pal_we) begin
            pal[pal_waddr] <= pal_wdata;
        end
    end

    // palette colour inside framebuffer, border elsewhere
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            colr_q <= '0;
        end else if (paint_area) begin
            colr_q <= pal[cidx];
        end else begin
            colr_q <= rgb_t'(`BORDER_COLR);
        end
    end

    // de is the delayed enable, in step with colr_q, so blanking shows black
    assign rgb = de ? colr_q : '0;

endmodule

// File: design/fb_display_top.sv
/* paletted framebuffer display top level: timing, host port,
   interleaved banks, fetch and colour lookup */
`timescale 1ns/1ps
`include "fb_consts.svh"

module fb_display_top import colour_pkg::*; import display_pkg::*; (
    input  logic       clk_pix,
    input  logic       rst_n,
    input  logic       req,     // host handshake
    output logic       ack,
    input  logic       wr_pal,
    input  fb_addr_t   wr_addr,
    input  host_word_u wr_data,
    output logic       hsync,   // video out, all FETCH_LAT behind timing
    output logic       vsync,
    output logic       de,
    output logic [3:0] r,
    output logic [3:0] g,
    output logic [3:0] b
);

    coord_t               sx;          // raw timing
    coord_t               sy;
    logic                 tm_hsync;
    logic                 tm_vsync;
    logic                 tm_de;
    logic [`FB_BANKS-1:0] bank_we;     // host to banks
    bank_addr_t           bank_waddr;
    cidx_t                bank_wdata;
    bank_addr_t           bank_raddr;  // fetch to banks
    cidx_t                bank_rdata [`FB_BANKS];
    logic                 pal_we;      // host to clut
    cidx_t                pal_waddr;
    rgb_t                 pal_wdata;
    cidx_t                cidx;        // fetch to clut
    logic                 paint_area;

    display_timing timing_inst (
        .clk_pix,
        .rst_n,
        .sx,
        .sy,
        .hsync (tm_hsync),
        .vsync (tm_vsync),
        .de    (tm_de),
        .frame ()          // fetch works from coordinates alone
    );

    fb_host_port host_inst (
        .clk_pix,
        .rst_n,
        .req,
        .ack,
        .wr_pal,
        .wr_addr,
        .wr_data,
        .bank_we,
        .bank_waddr,
        .bank_wdata,
        .pal_we,
        .pal_waddr,
        .pal_wdata
    );

    // four interleaved banks, shared addresses
    for (genvar i = 0; i < `FB_BANKS; i++) begin : g_bank
        fb_bank bank_inst (
            .clk_pix,
            .we    (bank_we[i]),
            .waddr (bank_waddr),
            .wdata (bank_wdata),
            .raddr (bank_raddr),
            .rdata (bank_rdata[i])
        );
    end

    fb_fetch fetch_inst (
        .clk_pix,
        .rst_n,
        .sx,
        .sy,
        .hsync      (tm_hsync),
        .vsync      (tm_vsync),
        .de         (tm_de),
        .bank_raddr,
        .bank_rdata,
        .cidx,
        .paint_area,
        .hsync_d    (hsync),
        .vsync_d    (vsync),
        .de_d       (de)
    );

    clut clut_inst (
        .clk_pix,
        .rst_n,
        .pal_we,
        .pal_waddr,
        .pal_wdata,
        .cidx,
        .paint_area,
        .de,
        .rgb        ({r, g, b}) // rgb_t field order
    );

endmodule

// File: verif/fb_checker.sv
/* display checker: snoops host writes into a model framebuffer
   and palette, compares every output pixel, handshake and frame shape */
`timescale 1ns/1ps
`include "fb_consts.svh"

module fb_checker (
    input  logic        clk_pix,
    input  logic        rst_n,
    input  logic        req,
    input  logic        ack,
    input  logic        wr_pal,
    input  logic [7:0]  wr_addr,
    input  logic [11:0] wr_data,
    input  logic        hsync,
    input  logic        vsync,
    input  logic        de,
    input  logic [3:0]  r,
    input  logic [3:0]  g,
    input  logic [3:0]  b,
    output int          pix_errs,   // wrong colour on screen
    output int          shake_errs, // handshake or reset state
    output int          frame_errs, // frame shape, hsync or repeat
    output int          fb_checks   // framebuffer pixels with a known colour
);

    localparam int IMG = `H_ACTIVE * `V_ACTIVE;

    logic [3:0]  fb_mem [`FB_PIXELS]; // all four banks in one array
    logic [11:0] pal_mem [16];
    logic [11:0] cur_img [IMG];       // visible area of this frame
    logic [11:0] prev_img [IMG];
    logic [11:0] rgb;
    logic [11:0] exp_rgb;
    logic        exp_hs;
    logic        ack_q = 1'b0;
    logic        req_q = 1'b0;        // req on the edge before
    logic        vs_q = 1'b0;
    logic        de_q = 1'b0;
    logic        rst_q = 1'b0;
    logic        y_valid = 1'b0;      // y counted from a vsync fall
    logic        cmp_en = 1'b0;       // no host traffic since frame start
    logic        prev_ok = 1'b0;
    int          x = 0;               // de cycles in this line
    int          y = 0;               // de lines since vsync fell
    int          hcnt = `H_TOTAL;     // cycles since the last de cycle
    int          rst_cnt = 0;
    int          mism;

    assign rgb = {r, g, b};

    // expected colour at output pixel (px, py)
    function automatic logic [11:0] ref_colour(int px, int py, logic den);
        if (!den) return 12'h000; // blanking
        if (px < `FB_WIDTH && py < `FB_HEIGHT) begin
            return pal_mem[fb_mem[py * `FB_WIDTH + px]];
        end
        return `BORDER_COLR;
    endfunction

    initial begin
        pix_errs   = 0;
        shake_errs = 0;
        frame_errs = 0;
        fb_checks  = 0;
    end

    always @(posedge clk_pix) begin
        // from the second reset cycle up to the first free one
        if (!rst_q && rst_cnt > 0) begin
            if ({hsync, vsync, de, ack, rgb} !== '0) begin
                $display("ERR %0t: outputs not low at reset, hs %b vs %b de %b ack %b rgb %h",
                         $time, hsync, vsync, de, ack, rgb);
                shake_errs++;
            end
        end
        if (!rst_n) begin
            rst_cnt++;
            y_valid = 1'b0;
            cmp_en  = 1'b0;
            prev_ok = 1'b0;
        end else if (rst_q) begin
            if (ack && !ack_q) begin // write landed one edge ago
                if (!req_q) begin
                    $display("ERR %0t: ack rose while req was low", $time);
                    shake_errs++;
                end
                if (wr_pal) begin
                    pal_mem[wr_addr[3:0]] = wr_data; // rgb view
                end else if (wr_addr < `FB_PIXELS) begin
                    fb_mem[wr_addr] = wr_data[3:0]; // index view
                end
            end
            if (req || ack) cmp_en = 1'b0;
            if (!de && rgb !== 12'h000) begin
                $display("ERR %0t: blanking pixel is %h, expected 000", $time, rgb);
                pix_errs++;
            end
            // hsync position within the blanking tail of a visible line
            if (de) hcnt = 0;
            else hcnt++;
            exp_hs = (hcnt > `HS_START - `H_ACTIVE) && (hcnt <= `HS_END - `H_ACTIVE);
            if (hcnt <= `H_TOTAL - `H_ACTIVE && hsync !== exp_hs) begin
                $display("ERR %0t: hsync is %b, expected %b", $time, hsync, exp_hs);
                frame_errs++;
            end
            if (de && y_valid && cmp_en) begin
                exp_rgb = ref_colour(x, y, de);
                if (!$isunknown(exp_rgb)) begin // unwritten memory skipped
                    if (rgb !== exp_rgb) begin
                        $display("ERR %0t: pixel (%0d,%0d) is %h, expected %h",
                                 $time, x, y, rgb, exp_rgb);
                        pix_errs++;
                    end else if (x < `FB_WIDTH && y < `FB_HEIGHT) begin
                        fb_checks++;
                    end
                end
                if (x < `H_ACTIVE && y < `V_ACTIVE) cur_img[y * `H_ACTIVE + x] = rgb;
            end
            if (de) x++;
            if (de_q && !de) begin // end of a visible line
                if (y_valid && x != `H_ACTIVE) begin
                    $display("ERR %0t: line %0d has %0d pixels", $time, y, x);
                    frame_errs++;
                end
                x = 0;
                y++;
            end
            if (vs_q && !vsync) begin // frame boundary
                if (y_valid && y != `V_ACTIVE) begin
                    $display("ERR %0t: frame has %0d lines", $time, y);
                    frame_errs++;
                end
                if (y_valid && cmp_en && prev_ok) begin
                    mism = 0;
                    for (int i = 0; i < IMG; i++) begin
                        if (cur_img[i] !== prev_img[i]) mism++;
                    end
                    if (mism != 0) begin
                        $display("ERR %0t: frame differs from the last in %0d pixels",
                                 $time, mism);
                        frame_errs++;
                    end
                end
                prev_img = cur_img;
                prev_ok  = y_valid && cmp_en;
                y        = 0;
                y_valid  = 1'b1;
                cmp_en   = !(req || ack);
            end
        end
        rst_q = rst_n;
        ack_q = ack;
        req_q = req;
        vs_q  = vsync;
        de_q  = de;
    end

endmodule

// File: verif/tb_fb_display.sv
/* testbench top: clock, reset, host writes over four-phase
   req/ack, test phases, watchdog and closing report */
`timescale 1ns/1ps
`include "fb_consts.svh"

module tb_fb_display;

    localparam time CLK_PERIOD = 40ns;
    localparam int  N_WRITES   = (`FB_PIXELS + 16) * 3; // bound, three write phases
    localparam int  N_FRAMES   = 9;                     // all frame waits together
    localparam int  WATCH_CYC  = N_WRITES * 8 + N_FRAMES * `H_TOTAL * `V_TOTAL + 50;

    logic        clk_pix;
    logic        rst_n;
    logic        req;
    logic        ack;
    logic        wr_pal;
    logic [7:0]  wr_addr;
    logic [11:0] wr_data;
    logic        hsync;
    logic        vsync;
    logic        de;
    logic [3:0]  r;
    logic [3:0]  g;
    logic [3:0]  b;
    int          seed = 52;
    int          host_errs = 0; // handshake timeouts
    int          pix_errs;
    int          shake_errs;
    int          frame_errs;
    int          fb_checks;

    fb_display_top uut (
        .clk_pix, .rst_n, .req, .ack, .wr_pal, .wr_addr, .wr_data,
        .hsync, .vsync, .de, .r, .g, .b
    );

    fb_checker chk (
        .clk_pix, .rst_n, .req, .ack, .wr_pal, .wr_addr, .wr_data,
        .hsync, .vsync, .de, .r, .g, .b,
        .pix_errs, .shake_errs, .frame_errs, .fb_checks
    );

    initial begin
        clk_pix = 1'b0;
        forever #(CLK_PERIOD / 2) clk_pix = ~clk_pix;
    end

    // bounded run
    initial begin
        #(WATCH_CYC * CLK_PERIOD);
        $display("watchdog: the run went past its time limit of %0d cycles", WATCH_CYC);
        $display("tests failed");
        $finish;
    end

    // one four-phase write, inputs change on the falling edge
    task automatic host_write(input logic pal, input logic [7:0] addr, input logic [11:0] data);
        int n;
        @(negedge clk_pix);
        wr_pal  = pal;
        wr_addr = addr;
        wr_data = data;
        req     = 1'b1;
        n = 0;
        do begin
            @(negedge clk_pix);
            n++;
        end while (!ack && n < 10);
        if (!ack) begin
            $display("host write to %h: ack did not rise within 10 cycles", addr);
            host_errs++;
        end
        req = 1'b0;
        n = 0;
        do begin
            @(negedge clk_pix);
            n++;
        end while (ack && n < 10);
        if (ack) begin
            $display("host write to %h: ack did not fall within 10 cycles", addr);
            host_errs++;
        end
    endtask

    task automatic wait_frames(input int n);
        repeat (n) @(negedge vsync); // frame starts as vsync falls
    endtask

    initial begin
        int         i;
        int         total;
        logic [3:0] hot; // palette entry rewritten
        rst_n   = 1'b0;
        req     = 1'b0;
        wr_pal  = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        repeat (10) @(negedge clk_pix);
        rst_n = 1'b1;
        wait_frames(2); // border and blanking only, memories unknown
        for (i = 0; i < 16; i++) begin
            host_write(1'b1, {4'($random(seed)), 4'(i)}, 12'($random(seed))); // junk high bits
        end
        for (i = 0; i < `FB_PIXELS; i++) begin
            host_write(1'b0, 8'(i), 12'($random(seed))); // pad bits random too
        end
        wait_frames(2);
        hot = 4'($random(seed));
        host_write(1'b1, {4'h0, hot}, 12'($random(seed)));
        wait_frames(2);
        for (i = 0; i < 16; i++) begin
            host_write(1'b0, 8'(`FB_PIXELS + ($random(seed) & 63)), 12'($random(seed)));
        end
        wait_frames(3); // two clean frames, same picture
        repeat (2) @(negedge clk_pix); // checker closes the last frame
        total = host_errs + pix_errs + shake_errs + frame_errs;
        if (fb_checks == 0) begin
            $display("no framebuffer pixel was compared against a known colour");
        end
        $display("errors: pixel %0d, handshake %0d, frame %0d, host %0d; fb pixels checked %0d",
                 pix_errs, shake_errs, frame_errs, host_errs, fb_checks);
        if (total == 0 && fb_checks > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+common
common/colour_pkg.sv
common/display_pkg.sv
design/display_timing.sv
framebuffer/fb_host_port.sv
framebuffer/fb_bank.sv
framebuffer/fb_fetch.sv
design/clut.sv
design/fb_display_top.sv
verif/fb_checker.sv
verif/tb_fb_display.sv

// File: Bender.yml
package:
  name: fb_display

export_include_dirs:
  - common

sources:
  - target: rtl
    include_dirs:
      - common
    files:
      - common/colour_pkg.sv
      - common/display_pkg.sv
      - design/display_timing.sv
      - framebuffer/fb_host_port.sv
      - framebuffer/fb_bank.sv
      - framebuffer/fb_fetch.sv
      - design/clut.sv
      - design/fb_display_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - verif/fb_checker.sv
      - verif/tb_fb_display.sv
